//--- icache_pkg.sv
// shared geometry constants, width helpers and controller states for the instruction cache
package icache_pkg;

  ////////////////////////////////////////////////////////////
  // address and fetch geometry
  ////////////////////////////////////////////////////////////

  // physical fetch address width
  localparam int unsigned addr_width  = 32;
  // one instruction word handed back to the fetch unit
  localparam int unsigned fetch_width = 32;

  ////////////////////////////////////////////////////////////
  // derived widths, evaluated per module from its parameters
  ////////////////////////////////////////////////////////////

  // set index bits
  function automatic int unsigned idx_bits(int unsigned num_sets);
    return $clog2(num_sets);
  endfunction

  // byte offset bits inside one line
  function automatic int unsigned off_bits(int unsigned line_bytes);
    return $clog2(line_bytes);
  endfunction

  // tag is whatever remains above index and offset
  function automatic int unsigned tag_bits(int unsigned num_sets, int unsigned line_bytes);
    return addr_width - idx_bits(num_sets) - off_bits(line_bytes);
  endfunction

  // way index, never narrower than one bit
  function automatic int unsigned way_bits(int unsigned num_ways);
    return (num_ways > 1) ? $clog2(num_ways) : 1;
  endfunction

  ////////////////////////////////////////////////////////////
  // controller FSM
  ////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    FLUSH,
    IDLE,
    READ,
    MISS
  } ctrl_state_e;

endpackage

//--- icache_store.sv
// icache tag, valid and line arrays per way, read out into registers on the read strobe
module icache_store #(
  parameter int unsigned NumWays   = 4,
  parameter int unsigned NumSets   = 16,
  parameter int unsigned LineBytes = 16,
  localparam int unsigned IdxW     = icache_pkg::idx_bits(NumSets),
  localparam int unsigned TagW     = icache_pkg::tag_bits(NumSets, LineBytes),
  localparam int unsigned WayW     = icache_pkg::way_bits(NumWays),
  localparam int unsigned LineW    = LineBytes * 8
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            rd_en_i,
  input  logic                            wr_en_i,
  input  logic                            clr_en_i,
  input  logic [IdxW-1:0]                 index_i,
  input  logic [TagW-1:0]                 tag_i,
  input  logic [WayW-1:0]                 wr_way_i,
  input  logic [LineW-1:0]                line_i,
  output logic [NumWays-1:0][TagW-1:0]    tag_o,
  output logic [NumWays-1:0]              vld_o,
  output logic [NumWays-1:0][LineW-1:0]   line_o
);

  logic [TagW-1:0]    tag_mem  [NumWays][NumSets];
  logic [LineW-1:0]   line_mem [NumWays][NumSets];
  // valid bits of a set sit together so a flush clears all ways at once
  logic [NumWays-1:0] vld_mem  [NumSets];

  ////////////////////////////////////////////////////////////
  // tag and line arrays
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    for (int w = 0; w < NumWays; w++) begin
      // refill goes into the victim way only
      if (wr_en_i && (wr_way_i == WayW'(w))) begin
        tag_mem[w][index_i]  <= tag_i;
        line_mem[w][index_i] <= line_i;
      end
      if (rd_en_i) begin
        tag_o[w]  <= tag_mem[w][index_i];
        line_o[w] <= line_mem[w][index_i];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // valid bits
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (clr_en_i) begin
      vld_mem[index_i] <= '0;
    end else if (wr_en_i) begin
      vld_mem[index_i][wr_way_i] <= 1'b1;
    end
  end

  // valid read-out starts empty so nothing hits before the first read
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      vld_o <= '0;
    end else if (rd_en_i) begin
      vld_o <= vld_mem[index_i];
    end
  end

endmodule

//--- icache_lookup.sv
// icache lookup: tag compare, fetch word select and replacement way choice
module icache_lookup #(
  parameter int unsigned NumWays   = 4,
  parameter int unsigned NumSets   = 16,
  parameter int unsigned LineBytes = 16,
  localparam int unsigned OffW     = icache_pkg::off_bits(LineBytes),
  localparam int unsigned TagW     = icache_pkg::tag_bits(NumSets, LineBytes),
  localparam int unsigned WayW     = icache_pkg::way_bits(NumWays),
  localparam int unsigned LineW    = LineBytes * 8
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  // latched request
  input  logic [TagW-1:0]                    tag_i,
  input  logic [OffW-1:0]                    offset_i,
  input  logic                               cmp_en_i,
  // refill write, for the replacement state
  input  logic                               upd_i,
  // set read-out from the store
  input  logic [NumWays-1:0][TagW-1:0]       way_tag_i,
  input  logic [NumWays-1:0]                 way_vld_i,
  input  logic [NumWays-1:0][LineW-1:0]      way_line_i,
  input  logic [LineW-1:0]                   rtrn_line_i,
  output logic                               hit_o,
  output logic [WayW-1:0]                    victim_o,
  output logic [icache_pkg::fetch_width-1:0] data_o
);

  import icache_pkg::*;

  logic [NumWays-1:0] way_hit;
  logic [WayW-1:0]    hit_way;
  logic [WayW-1:0]    inv_way;
  logic               all_valid;
  // word position inside the line
  logic [OffW-3:0]    word_sel;
  logic [7:0]         lfsr_q;

  ////////////////////////////////////////////////////////////
  // tag compare and word select
  ////////////////////////////////////////////////////////////

  for (genvar w = 0; w < NumWays; w++) begin : gen_cmp
    assign way_hit[w] = way_vld_i[w] && (way_tag_i[w] == tag_i);
  end

  // walk down so the lowest matching way wins
  always_comb begin
    hit_way = '0;
    for (int w = NumWays - 1; w >= 0; w--) begin
      if (way_hit[w]) begin
        hit_way = WayW'(w);
      end
    end
  end

  // no hit is reported while compare is off
  assign hit_o    = cmp_en_i & (|way_hit);
  assign word_sel = offset_i[OffW-1:2];

  // hit line during lookup, refill line on the return
  always_comb begin
    if (cmp_en_i) begin
      data_o = way_line_i[hit_way][word_sel * fetch_width +: fetch_width];
    end else begin
      data_o = rtrn_line_i[word_sel * fetch_width +: fetch_width];
    end
  end

  ////////////////////////////////////////////////////////////
  // replacement
  ////////////////////////////////////////////////////////////

  assign all_valid = &way_vld_i;

  // lowest empty way first
  always_comb begin
    inv_way = '0;
    for (int w = NumWays - 1; w >= 0; w--) begin
      if (!way_vld_i[w]) begin
        inv_way = WayW'(w);
      end
    end
  end

  // full set, fall back to the pseudo-random way
  assign victim_o = all_valid ? lfsr_q[WayW-1:0] : inv_way;

  // 8-bit fibonacci LFSR, taps 8 6 5 4
  // steps only when a refill evicts a valid line
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q <= 8'h5a;
    end else if (upd_i && all_valid) begin
      lfsr_q <= {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
    end
  end

endmodule

//--- icache_ctrl.sv
// icache controller: request FSM, flush sequencing and refill requests toward memory
module icache_ctrl #(
  parameter int unsigned NumWays   = 4,
  parameter int unsigned NumSets   = 16,
  parameter int unsigned LineBytes = 16,
  localparam int unsigned IdxW     = icache_pkg::idx_bits(NumSets),
  localparam int unsigned OffW     = icache_pkg::off_bits(LineBytes),
  localparam int unsigned TagW     = icache_pkg::tag_bits(NumSets, LineBytes),
  localparam int unsigned WayW     = icache_pkg::way_bits(NumWays)
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  // fetch side
  input  logic                              req_i,
  input  logic [icache_pkg::addr_width-1:0] addr_i,
  output logic                              ready_o,
  output logic                              valid_o,
  // enable, flush and perf counter
  input  logic                              en_i,
  input  logic                              flush_i,
  output logic                              miss_o,
  // lookup results
  input  logic                              hit_i,
  input  logic [WayW-1:0]                   victim_i,
  // memory side
  output logic                              mem_req_o,
  output logic [icache_pkg::addr_width-1:0] mem_addr_o,
  output logic                              mem_nc_o,
  input  logic                              mem_ack_i,
  input  logic                              mem_rtrn_vld_i,
  // array control
  output logic                              rd_en_o,
  output logic                              wr_en_o,
  output logic                              clr_en_o,
  output logic [IdxW-1:0]                   index_o,
  output logic [TagW-1:0]                   tag_o,
  output logic [WayW-1:0]                   way_o,
  output logic [OffW-1:0]                   offset_o,
  output logic                              cmp_en_o
);

  import icache_pkg::*;

  ctrl_state_e            state_d, state_q;
  // cache enable, only set again by passing through FLUSH
  logic                   cache_en_d, cache_en_q;
  // flush requests wait here until IDLE
  logic                   flush_d, flush_q;
  // tag compare valid in the next cycle
  logic                   cmp_en_d, cmp_en_q;
  logic                   flush_en, flush_done;
  logic [IdxW-1:0]        flush_cnt_d, flush_cnt_q;
  // latched fetch address and the way picked for refill
  logic [addr_width-1:0]  addr_d, addr_q;
  logic [WayW-1:0]        way_d, way_q;

  ////////////////////////////////////////////////////////////
  // address plumbing
  ////////////////////////////////////////////////////////////

  // take a new address only on an accepted fetch
  assign addr_d = rd_en_o ? addr_i : addr_q;

  // flush walks the sets, otherwise the array follows the next address
  assign index_o  = flush_en ? flush_cnt_q : addr_d[OffW +: IdxW];
  assign tag_o    = addr_q[addr_width-1 -: TagW];
  assign offset_o = addr_q[OffW-1:0];

  // refill is always a whole line
  assign mem_addr_o = {addr_q[addr_width-1:OffW], {OffW{1'b0}}};
  // a disabled cache forwards fetches as non-cacheable
  assign mem_nc_o   = ~cache_en_q;

  // victim sampled while the set read-out sits in the store
  assign way_d = (state_q == READ) ? victim_i : way_q;
  assign way_o = way_q;

  assign cmp_en_o = cmp_en_q;
  assign clr_en_o = flush_en;

  ////////////////////////////////////////////////////////////
  // flush counter
  ////////////////////////////////////////////////////////////

  assign flush_done  = (flush_cnt_q == IdxW'(NumSets - 1));
  assign flush_cnt_d = flush_done ? '0 :
                       flush_en   ? flush_cnt_q + 1'b1 :
                                    flush_cnt_q;

  ////////////////////////////////////////////////////////////
  // main FSM
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d    = state_q;
    // disable acts at once, enable goes through a flush
    cache_en_d = cache_en_q & en_i;
    flush_d    = flush_q | flush_i;
    cmp_en_d   = 1'b0;
    flush_en   = 1'b0;
    ready_o    = 1'b0;
    valid_o    = 1'b0;
    miss_o     = 1'b0;
    mem_req_o  = 1'b0;
    rd_en_o    = 1'b0;
    wr_en_o    = 1'b0;

    unique case (state_q)
      // clear one set per cycle
      FLUSH: begin
        flush_en = 1'b1;
        if (flush_done) begin
          state_d    = IDLE;
          flush_d    = 1'b0;
          cache_en_d = en_i;
        end
      end
      // wait for a fetch
      IDLE: begin
        cmp_en_d = cache_en_q;
        if (flush_d || (en_i && !cache_en_q)) begin
          state_d = FLUSH;
        end else begin
          ready_o = 1'b1;
          if (req_i) begin
            rd_en_o = 1'b1;
            state_d = READ;
          end
        end
      end
      // set read-out is in the store, check for a hit
      READ: begin
        if (hit_i) begin
          valid_o  = 1'b1;
          state_d  = IDLE;
          cmp_en_d = cache_en_q;
          // stream the next fetch unless a flush waits
          if (!flush_d) begin
            ready_o = 1'b1;
            if (req_i) begin
              rd_en_o = 1'b1;
              state_d = READ;
            end
          end
        end else begin
          // miss or disabled cache, hold the request until acked
          mem_req_o = 1'b1;
          if (mem_ack_i) begin
            miss_o  = cache_en_q;
            state_d = MISS;
          end
        end
      end
      // wait for the line, write it back only if cacheable
      MISS: begin
        if (mem_rtrn_vld_i) begin
          valid_o = 1'b1;
          wr_en_o = cache_en_q;
          state_d = IDLE;
        end
      end
      default: begin
        state_d = FLUSH;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= FLUSH;
      cache_en_q  <= 1'b0;
      flush_q     <= 1'b0;
      cmp_en_q    <= 1'b0;
      flush_cnt_q <= '0;
    end else begin
      state_q     <= state_d;
      cache_en_q  <= cache_en_d;
      flush_q     <= flush_d;
      cmp_en_q    <= cmp_en_d;
      flush_cnt_q <= flush_cnt_d;
    end
  end

  always_ff @(posedge clk_i) begin
    addr_q <= addr_d;
    way_q  <= way_d;
  end

endmodule

//--- icache_top.sv
// set-associative instruction cache top level, connect the fetch unit and a line-wide memory port
module icache_top #(
  parameter int unsigned NumWays   = 4,
  parameter int unsigned NumSets   = 16,
  parameter int unsigned LineBytes = 16,
  localparam int unsigned IdxW     = icache_pkg::idx_bits(NumSets),
  localparam int unsigned OffW     = icache_pkg::off_bits(LineBytes),
  localparam int unsigned TagW     = icache_pkg::tag_bits(NumSets, LineBytes),
  localparam int unsigned WayW     = icache_pkg::way_bits(NumWays),
  localparam int unsigned LineW    = LineBytes * 8
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  // fetch side
  input  logic                               req_i,
  input  logic [icache_pkg::addr_width-1:0]  addr_i,
  output logic                               ready_o,
  output logic                               valid_o,
  output logic [icache_pkg::fetch_width-1:0] data_o,
  // enable, flush and perf counter
  input  logic                               en_i,
  input  logic                               flush_i,
  output logic                               miss_o,
  // memory side, one line per return
  output logic                               mem_req_o,
  output logic [icache_pkg::addr_width-1:0]  mem_addr_o,
  output logic                               mem_nc_o,
  input  logic                               mem_ack_i,
  input  logic                               mem_rtrn_vld_i,
  input  logic [LineW-1:0]                   mem_rtrn_data_i
);

  // controller to store and lookup
  logic                            rd_en, wr_en, clr_en, cmp_en;
  logic [IdxW-1:0]                 index;
  logic [TagW-1:0]                 tag;
  logic [WayW-1:0]                 wr_way;
  logic [OffW-1:0]                 offset;
  // store read-out
  logic [NumWays-1:0][TagW-1:0]    way_tag;
  logic [NumWays-1:0]              way_vld;
  logic [NumWays-1:0][LineW-1:0]   way_line;
  // lookup back to the controller
  logic                            hit;
  logic [WayW-1:0]                 victim;

  icache_ctrl #(
    .NumWays   (NumWays),
    .NumSets   (NumSets),
    .LineBytes (LineBytes)
  ) u_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (req_i),
    .addr_i         (addr_i),
    .ready_o        (ready_o),
    .valid_o        (valid_o),
    .en_i           (en_i),
    .flush_i        (flush_i),
    .miss_o         (miss_o),
    .hit_i          (hit),
    .victim_i       (victim),
    .mem_req_o      (mem_req_o),
    .mem_addr_o     (mem_addr_o),
    .mem_nc_o       (mem_nc_o),
    .mem_ack_i      (mem_ack_i),
    .mem_rtrn_vld_i (mem_rtrn_vld_i),
    .rd_en_o        (rd_en),
    .wr_en_o        (wr_en),
    .clr_en_o       (clr_en),
    .index_o        (index),
    .tag_o          (tag),
    .way_o          (wr_way),
    .offset_o       (offset),
    .cmp_en_o       (cmp_en)
  );

  icache_store #(
    .NumWays   (NumWays),
    .NumSets   (NumSets),
    .LineBytes (LineBytes)
  ) u_store (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .rd_en_i  (rd_en),
    .wr_en_i  (wr_en),
    .clr_en_i (clr_en),
    .index_i  (index),
    .tag_i    (tag),
    .wr_way_i (wr_way),
    .line_i   (mem_rtrn_data_i),
    .tag_o    (way_tag),
    .vld_o    (way_vld),
    .line_o   (way_line)
  );

  icache_lookup #(
    .NumWays   (NumWays),
    .NumSets   (NumSets),
    .LineBytes (LineBytes)
  ) u_lookup (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .tag_i       (tag),
    .offset_i    (offset),
    .cmp_en_i    (cmp_en),
    .upd_i       (wr_en),
    .way_tag_i   (way_tag),
    .way_vld_i   (way_vld),
    .way_line_i  (way_line),
    .rtrn_line_i (mem_rtrn_data_i),
    .hit_o       (hit),
    .victim_o    (victim),
    .data_o      (data_o)
  );

endmodule

//--- tb_icache.sv
// testbench for the instruction cache, runs the operations listed in icache_tests.txt
module tb_icache;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned NumWays   = 4;
  localparam int unsigned NumSets   = 16;
  localparam int unsigned LineBytes = 16;
  localparam int unsigned LineW     = LineBytes * 8;
  localparam int unsigned MaxOps    = 64;

  // operation codes of the data file
  typedef enum logic [3:0] {
    OP_FETCH   = 4'h0,
    OP_FLUSH   = 4'h1,
    OP_DISABLE = 4'h2,
    OP_ENABLE  = 4'h3,
    OP_GEN     = 4'h4,
    OP_END     = 4'hf
  } op_e;

  logic             clk_i = 1'b0;
  logic             rst_ni, req_i, en_i, flush_i, mem_ack_i, mem_rtrn_vld_i;
  logic [31:0]      addr_i;
  logic [LineW-1:0] mem_rtrn_data_i;
  logic             ready_o, valid_o, miss_o, mem_req_o, mem_nc_o;
  logic [31:0]      data_o, mem_addr_o;

  // four words per operation: opcode, address, expected word, expected miss kind
  logic [31:0]      tests [0:4*MaxOps-1];
  int unsigned      num_ops, limit, cycle_cnt, err_cnt, fail_cnt;
  // memory model bookkeeping
  int unsigned      req_cnt, miss_cnt;
  logic             last_nc;
  logic [31:0]      last_addr, generation, lcg_state;

  icache_top #(
    .NumWays   (NumWays),
    .NumSets   (NumSets),
    .LineBytes (LineBytes)
  ) u_icache_top (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_i           (req_i),
    .addr_i          (addr_i),
    .ready_o         (ready_o),
    .valid_o         (valid_o),
    .data_o          (data_o),
    .en_i            (en_i),
    .flush_i         (flush_i),
    .miss_o          (miss_o),
    .mem_req_o       (mem_req_o),
    .mem_addr_o      (mem_addr_o),
    .mem_nc_o        (mem_nc_o),
    .mem_ack_i       (mem_ack_i),
    .mem_rtrn_vld_i  (mem_rtrn_vld_i),
    .mem_rtrn_data_i (mem_rtrn_data_i)
  );

  always #5 clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
      err_cnt++;
    end
  endtask

  // kind 0 hit, 1 cacheable miss, 2 non-cacheable forward
  task automatic run_fetch(input logic [31:0] addr, input logic [31:0] exp_word,
                           input logic [31:0] kind);
    int unsigned req_before;
    int unsigned miss_before;
    @(posedge clk_i);
    #1;
    req_before  = req_cnt;
    miss_before = miss_cnt;
    req_i       = 1'b1;
    addr_i      = addr;
    // hold the request until the cache takes it
    @(negedge clk_i);
    while (!ready_o) @(negedge clk_i);
    @(posedge clk_i);
    #1;
    req_i = 1'b0;
    @(negedge clk_i);
    if (kind == 0) begin
      // hit data is due exactly one cycle after acceptance
      check_value("valid_o", valid_o, 1'b1);
      // hits stream, the next fetch may follow at once
      check_value("ready_o", ready_o, 1'b1);
      check_value("mem_req_o", mem_req_o, 1'b0);
    end else begin
      while (!valid_o) @(negedge clk_i);
    end
    check_value("data_o", data_o, exp_word);
    check_value("mem requests", req_cnt - req_before, (kind == 0) ? 0 : 1);
    check_value("miss_o pulses", miss_cnt - miss_before, (kind == 1) ? 1 : 0);
    if (kind != 0) begin
      check_value("mem_nc_o", last_nc, (kind == 2));
      check_value("mem_addr_o", last_addr, addr & ~(LineBytes - 1));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // memory model, random ack and return delays
  ////////////////////////////////////////////////////////////

  initial begin : mem_model
    logic [31:0] line_addr;
    forever begin
      @(posedge clk_i);
      #1;
      if (rst_ni && mem_req_o) begin
        line_addr = mem_addr_o;
        lcg_state = lcg_next(lcg_state);
        repeat (lcg_state[17:16]) begin
          @(posedge clk_i);
          #1;
          // request must stay up and steady until acked
          check_value("mem_req_o", mem_req_o, 1'b1);
          check_value("mem_addr_o", mem_addr_o, line_addr);
        end
        mem_ack_i = 1'b1;
        req_cnt++;
        last_nc   = mem_nc_o;
        last_addr = line_addr;
        @(posedge clk_i);
        #1;
        mem_ack_i = 1'b0;
        lcg_state = lcg_next(lcg_state);
        repeat (lcg_state[17:16]) begin
          @(posedge clk_i);
          #1;
        end
        // word i holds its own byte address xor the generation
        for (int i = 0; i < LineBytes / 4; i++) begin
          mem_rtrn_data_i[32*i +: 32] = (line_addr + 4 * i) ^ generation;
        end
        mem_rtrn_vld_i = 1'b1;
        @(posedge clk_i);
        #1;
        mem_rtrn_vld_i = 1'b0;
      end
    end
  end

  // miss pulses counted mid-cycle
  always @(negedge clk_i) begin
    if (rst_ni && miss_o) begin
      miss_cnt++;
    end
  end

  ////////////////////////////////////////////////////////////
  // timeout
  ////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    cycle_cnt++;
  end

  initial begin : watchdog
    wait (limit != 0);
    while (cycle_cnt < limit) @(posedge clk_i);
    $display("timeout after %0d cycles, the cache stopped answering", cycle_cnt);
    $display("Finished with errors");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // test runner
  ////////////////////////////////////////////////////////////

  initial begin : runner
    op_e         op;
    int unsigned errs_before;
    rst_ni          = 1'b0;
    req_i           = 1'b0;
    addr_i          = '0;
    en_i            = 1'b1;
    flush_i         = 1'b0;
    mem_ack_i       = 1'b0;
    mem_rtrn_vld_i  = 1'b0;
    mem_rtrn_data_i = '0;
    generation      = '0;
    lcg_state       = 32'h4d324879;
    $readmemh("icache_tests.txt", tests);
    num_ops = 0;
    while (num_ops < MaxOps && tests[4*num_ops][3:0] != OP_END) num_ops++;
    limit = 40 * num_ops + NumSets;

    repeat (8) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    for (int i = 0; i < num_ops; i++) begin
      op          = op_e'(tests[4*i][3:0]);
      errs_before = err_cnt;
      case (op)
        OP_FETCH: begin
          run_fetch(tests[4*i+1], tests[4*i+2], tests[4*i+3]);
        end
        OP_FLUSH: begin
          @(posedge clk_i);
          #1;
          flush_i = 1'b1;
          @(posedge clk_i);
          #1;
          flush_i = 1'b0;
        end
        OP_DISABLE: begin
          @(posedge clk_i);
          #1;
          en_i = 1'b0;
          repeat (2) @(posedge clk_i);
        end
        OP_ENABLE: begin
          @(posedge clk_i);
          #1;
          en_i = 1'b1;
        end
        OP_GEN: begin
          // address column carries the new generation
          generation = tests[4*i+1];
        end
        default: begin
          $display("test %0d has unknown opcode 0x%0h", i, tests[4*i]);
          err_cnt++;
        end
      endcase
      if (err_cnt != errs_before) begin
        fail_cnt++;
      end
      $display("test %0d %s addr 0x%08h %s", i, op.name(), tests[4*i+1],
               (err_cnt == errs_before) ? "ok" : "FAILED");
    end

    $display("%0d tests, %0d failed, %0d check errors", num_ops, fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

//--- icache_tests.txt
// columns: opcode address expected_word miss_kind (hex)
// opcode 0 fetch 1 flush 2 disable 3 enable 4 generation f end, miss_kind 0 hit 1 miss 2 nc
// first fetch misses, second word of the line hits
0 00000030 00000030 1
0 00000038 00000038 0
// fill all four ways of set 3 and read them back
0 00000134 00000134 1
0 00000238 00000238 1
0 0000033c 0000033c 1
0 00000130 00000130 0
0 00000230 00000230 0
0 00000330 00000330 0
0 00000034 00000034 0
// fifth line in a full set
0 00000430 00000430 1
0 0000043c 0000043c 0
// stale data until flushed
0 00000054 00000054 1
4 55aa0000 00000000 0
0 00000058 00000058 0
1 00000000 00000000 0
0 00000058 55aa0058 1
0 0000005c 55aa005c 0
// disabled cache forwards every fetch
2 00000000 00000000 0
0 00000058 55aa0058 2
0 00000058 55aa0058 2
4 11110000 00000000 0
0 00000054 11110054 2
0 00000070 11110070 2
// enable flushes, old line misses again
3 00000000 00000000 0
0 00000054 11110054 1
0 00000050 11110050 0
f 00000000 00000000 0

//--- all.f
icache_pkg.sv
icache_store.sv
icache_lookup.sv
icache_ctrl.sv
icache_top.sv
tb_icache.sv

//--- Makefile
# Verilator build, run, lint and clean for the instruction cache

VERILATOR ?= verilator
TB_TOP    ?= tb_icache
RTL_TOP   ?= icache_top
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only -Wall
RTL_SRCS  ?= icache_pkg.sv icache_store.sv icache_lookup.sv icache_ctrl.sv icache_top.sv
PASS_MSG  ?= Finished with no errors

SRCS := $(shell cat $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all run lint clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR)
